//--- rtl/mvm_cfg_pkg.sv
package mvm_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Matrix and element sizes
    ////////////////////////////////////////////////////////////

    // Vector length, also rows per column
    localparam int MAT_HEIGHT = 5;
    // Columns and results per vector
    localparam int MAT_WIDTH  = 20;
    localparam int ELEM_WIDTH = 8;
    localparam int RES_WIDTH  = 12;
    // Full product, then room for MAT_HEIGHT of them
    localparam int PROD_WIDTH = 2 * ELEM_WIDTH;
    localparam int ACC_WIDTH  = PROD_WIDTH + $clog2(MAT_HEIGHT);
    // Saturation bounds of a result
    localparam int RES_MAX    = (1 << (RES_WIDTH - 1)) - 1;
    localparam int RES_MIN    = -(1 << (RES_WIDTH - 1));

    // Fraction shift
    localparam int SHIFT_WIDTH  = 4;
    localparam int FRAC_DEFAULT = 4;

    ////////////////////////////////////////////////////////////
    // Credit depths
    ////////////////////////////////////////////////////////////

    localparam int VEC_CREDITS   = 1;
    localparam int COL_CREDITS   = 2;
    localparam int RES_CREDITS   = 4;
    // Stage-1 slots of the MAC pipeline
    localparam int MAC_CREDITS   = 2;
    localparam int COL_PTR_WIDTH = $clog2(COL_CREDITS);
    localparam int COL_CNT_WIDTH = $clog2(COL_CREDITS + 1);
    localparam int RES_CNT_WIDTH = $clog2(RES_CREDITS + 1);
    localparam int MAC_CNT_WIDTH = $clog2(MAC_CREDITS + 1);

    // Register bus, address 0 unmapped and reads zero
    localparam int CFG_WIDTH   = 16;
    localparam int ADDR_WIDTH  = 2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SHIFT  = 2'd1;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 2'd2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_COUNT  = 2'd3;

endpackage

//--- rtl/mvm_types_pkg.sv
package mvm_types_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////

    // One signed vector or matrix element
    typedef logic signed [mvm_cfg_pkg::ELEM_WIDTH-1:0] elem_t;

    // Whole vector, or one matrix column
    // Element 0 sits in the low bits
    typedef elem_t [mvm_cfg_pkg::MAT_HEIGHT-1:0] vec_t;

    // Single product of two elements
    typedef logic signed [mvm_cfg_pkg::PROD_WIDTH-1:0] prod_t;

    // Sum of all products of one column
    typedef logic signed [mvm_cfg_pkg::ACC_WIDTH-1:0] acc_t;

    // Shifted and saturated result
    typedef logic signed [mvm_cfg_pkg::RES_WIDTH-1:0] res_t;

    ////////////////////////////////////////////////////////////
    // Control types
    ////////////////////////////////////////////////////////////

    typedef logic [mvm_cfg_pkg::ADDR_WIDTH-1:0] csr_addr_t;

    // Work item for the MAC
    // Vector travels beside the column it multiplies
    typedef struct packed {
        vec_t vec;
        vec_t col;
    } pair_t;

endpackage

//--- rtl/mvm_stream_if.sv
// Credit-based stream
//
// Sender starts with as many credits as the receiver has slots,
// spends one per valid beat and gets one back per credit pulse.
// No ready signal; a beat with valid is always taken.
interface mvm_stream_if #(
    parameter type payload_t = logic
);

    // Sender side
    logic     valid;
    payload_t data;
    // Marks final item of a group
    logic     last;

    // Receiver side, one pulse per freed slot
    logic     credit;

    modport tx (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport rx (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface

//--- rtl/mvm_csr.sv
module mvm_csr (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cfg_we,
    input  mvm_types_pkg::csr_addr_t            cfg_addr,
    input  logic [mvm_cfg_pkg::CFG_WIDTH-1:0]   cfg_wdata,
    output logic [mvm_cfg_pkg::CFG_WIDTH-1:0]   cfg_rdata,
    output logic [mvm_cfg_pkg::SHIFT_WIDTH-1:0] frac_shift,
    input  logic                                overflow,
    input  logic                                res_fire,
    output logic                                error
);

    import mvm_cfg_pkg::*;

    logic [SHIFT_WIDTH-1:0] frac_q;
    logic                   ovf_flag;
    logic [CFG_WIDTH-1:0]   res_count;
    logic                   wr_shift;
    logic                   clr_ovf;

    // Decoded writes
    assign wr_shift = cfg_we && (cfg_addr == ADDR_SHIFT);
    // Only bit 0 of STATUS acts as clear
    assign clr_ovf  = cfg_we && (cfg_addr == ADDR_STATUS) && cfg_wdata[0];

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frac_q <= SHIFT_WIDTH'(FRAC_DEFAULT);
        end else if (wr_shift) begin
            frac_q <= cfg_wdata[SHIFT_WIDTH-1:0];
        end
    end

    // Sticky overflow
    // A new overflow beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_flag <= 1'b0;
        end else if (res_fire && overflow) begin
            ovf_flag <= 1'b1;
        end else if (clr_ovf) begin
            ovf_flag <= 1'b0;
        end
    end

    // Result counter, wraps at 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_count <= '0;
        end else if (res_fire) begin
            res_count <= res_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read mux, combinational from address
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cfg_addr)
            ADDR_SHIFT:  cfg_rdata = {{(CFG_WIDTH - SHIFT_WIDTH){1'b0}}, frac_q};
            ADDR_STATUS: cfg_rdata = {{(CFG_WIDTH - 1){1'b0}}, ovf_flag};
            ADDR_COUNT:  cfg_rdata = res_count;
            default:     cfg_rdata = '0;
        endcase
    end

    assign frac_shift = frac_q;
    assign error      = ovf_flag;

endmodule

//--- rtl/mvm_sequencer.sv
module mvm_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                vec_valid,
    input  mvm_types_pkg::vec_t vec_data,
    output logic                vec_credit,
    input  logic                col_valid,
    input  mvm_types_pkg::vec_t col_data,
    input  logic                last,
    output logic                col_credit,
    mvm_stream_if.tx            col_out,
    input  logic                res_credit_return
);

    import mvm_cfg_pkg::*;
    import mvm_types_pkg::*;

    // Vector slot
    vec_t vec_q;
    logic vec_loaded;

    // Column FIFO
    vec_t                   fifo_col  [COL_CREDITS];
    logic                   fifo_last [COL_CREDITS];
    logic [COL_PTR_WIDTH-1:0] wr_ptr;
    logic [COL_PTR_WIDTH-1:0] rd_ptr;
    logic [COL_CNT_WIDTH-1:0] fifo_cnt;
    logic                   fifo_wr;
    logic                   fifo_rd;
    logic                   fifo_full;
    logic                   fifo_empty;

    // Credits held toward consumer and MAC
    logic [RES_CNT_WIDTH-1:0] res_cnt;
    logic [MAC_CNT_WIDTH-1:0] mac_cnt;
    logic                     issue;

    ////////////////////////////////////////////////////////////
    // Vector register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (vec_valid) begin
            vec_q <= vec_data;
        end
    end

    // Released when the last column goes out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vec_loaded <= 1'b0;
        end else begin
            if (vec_credit) begin
                vec_loaded <= 1'b0;
            end
            if (vec_valid) begin
                vec_loaded <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Column FIFO
    ////////////////////////////////////////////////////////////

    // Sender only sends with a credit, so no full check here
    assign fifo_wr    = col_valid;
    assign fifo_rd    = issue;
    assign fifo_full  = (fifo_cnt == COL_CNT_WIDTH'(COL_CREDITS));
    assign fifo_empty = (fifo_cnt == '0);

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_col[wr_ptr]  <= col_data;
            fifo_last[wr_ptr] <= last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= (wr_ptr == COL_PTR_WIDTH'(COL_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_rd) begin
                rd_ptr <= (rd_ptr == COL_PTR_WIDTH'(COL_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + COL_CNT_WIDTH'(fifo_wr) - COL_CNT_WIDTH'(fifo_rd);
        end
    end

    ////////////////////////////////////////////////////////////
    // Credit counters and issue
    ////////////////////////////////////////////////////////////

    // Spent on issue, so results in flight are already counted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_cnt <= RES_CNT_WIDTH'(RES_CREDITS);
            mac_cnt <= MAC_CNT_WIDTH'(MAC_CREDITS);
        end else begin
            res_cnt <= res_cnt + RES_CNT_WIDTH'(res_credit_return) - RES_CNT_WIDTH'(issue);
            mac_cnt <= mac_cnt + MAC_CNT_WIDTH'(col_out.credit) - MAC_CNT_WIDTH'(issue);
        end
    end

    assign issue = vec_loaded && !fifo_empty && (res_cnt != '0) && (mac_cnt != '0);

    // Head column plus current vector
    assign col_out.valid = issue;
    assign col_out.data  = pair_t'{vec: vec_q, col: fifo_col[rd_ptr]};
    assign col_out.last  = fifo_last[rd_ptr];

    // Upstream credit returns
    assign col_credit = issue;
    assign vec_credit = issue && fifo_last[rd_ptr];

endmodule

//--- rtl/mvm_vector_mac.sv
module mvm_vector_mac (
    input  logic                                clk,
    input  logic                                rst_n,
    mvm_stream_if.rx                            col_in,
    input  logic [mvm_cfg_pkg::SHIFT_WIDTH-1:0] frac_shift,
    mvm_stream_if.tx                            res_out,
    output logic                                overflow
);

    import mvm_cfg_pkg::*;
    import mvm_types_pkg::*;

    // Stage 1
    prod_t                  s1_prod [MAT_HEIGHT];
    logic [SHIFT_WIDTH-1:0] s1_shift;
    logic                   s1_valid;
    logic                   s1_last;

    // Between the stages
    acc_t sum;
    acc_t shifted;
    res_t sat;
    logic clamp;

    // Stage 2
    res_t s2_res;
    logic s2_ovf;
    logic s2_valid;
    logic s2_last;

    ////////////////////////////////////////////////////////////
    // Stage 1: element products
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= col_in.valid;
        end
    end

    // Shift is captured with the column it applies to
    always_ff @(posedge clk) begin
        if (col_in.valid) begin
            for (int i = 0; i < MAT_HEIGHT; i++) begin
                s1_prod[i] <= $signed(col_in.data.col[i]) * $signed(col_in.data.vec[i]);
            end
            s1_shift <= frac_shift;
            s1_last  <= col_in.last;
        end
    end

    // Stage-1 slot frees as its column moves on
    assign col_in.credit = s1_valid;

    ////////////////////////////////////////////////////////////
    // Stage 2: sum, shift, saturate
    ////////////////////////////////////////////////////////////

    always_comb begin
        sum = '0;
        for (int i = 0; i < MAT_HEIGHT; i++) begin
            sum = sum + s1_prod[i];
        end
        // Arithmetic shift, rounds toward minus infinity
        shifted = sum >>> s1_shift;
        clamp   = 1'b1;
        if (shifted > RES_MAX) begin
            sat = res_t'(RES_MAX);
        end else if (shifted < RES_MIN) begin
            sat = res_t'(RES_MIN);
        end else begin
            sat   = res_t'(shifted);
            clamp = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_res  <= sat;
            s2_ovf  <= clamp;
            s2_last <= s1_last;
        end
    end

    // Result stream, two cycles after col_in.valid
    assign res_out.valid = s2_valid;
    assign res_out.data  = s2_res;
    assign res_out.last  = s2_last;
    // Qualified by res_out.valid
    assign overflow      = s2_ovf;

endmodule

//--- rtl/mvm_top.sv
module mvm_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // Vector stream
    input  logic                                vec_valid,
    input  mvm_types_pkg::vec_t                 vec_data,
    output logic                                vec_credit,
    // Column stream
    input  logic                                col_valid,
    input  mvm_types_pkg::vec_t                 col_data,
    input  logic                                col_last,
    output logic                                col_credit,
    // Result stream
    output logic                                res_valid,
    output mvm_types_pkg::res_t                 res_data,
    input  logic                                res_credit,
    // Register bus
    input  logic                                cfg_we,
    input  mvm_types_pkg::csr_addr_t            cfg_addr,
    input  logic [mvm_cfg_pkg::CFG_WIDTH-1:0]   cfg_wdata,
    output logic [mvm_cfg_pkg::CFG_WIDTH-1:0]   cfg_rdata,
    output logic                                error
);

    import mvm_cfg_pkg::*;
    import mvm_types_pkg::*;

    logic [SHIFT_WIDTH-1:0] frac_shift;
    logic                   overflow;

    // Sequencer to MAC, and MAC to result ports
    mvm_stream_if #(.payload_t(pair_t)) col_if ();
    mvm_stream_if #(.payload_t(res_t))  res_if ();

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    mvm_sequencer u_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .vec_valid         (vec_valid),
        .vec_data          (vec_data),
        .vec_credit        (vec_credit),
        .col_valid         (col_valid),
        .col_data          (col_data),
        .last              (col_last),
        .col_credit        (col_credit),
        .col_out           (col_if.tx),
        .res_credit_return (res_if.credit)
    );

    mvm_vector_mac u_vector_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_in     (col_if.rx),
        .frac_shift (frac_shift),
        .res_out    (res_if.tx),
        .overflow   (overflow)
    );

    mvm_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .frac_shift (frac_shift),
        .overflow   (overflow),
        .res_fire   (res_if.valid),
        .error      (error)
    );

    // Consumer side of the result stream
    assign res_valid     = res_if.valid;
    assign res_data      = res_if.data;
    assign res_if.credit = res_credit;

endmodule

//--- testbench/mvm_assert.sv
module mvm_assert (
    input logic                                    clk,
    input logic                                    rst_n,
    input logic [mvm_cfg_pkg::RES_CNT_WIDTH-1:0]   res_cnt,
    input logic                                    fifo_wr,
    input logic                                    fifo_full,
    input logic                                    issue,
    input logic                                    vec_valid,
    input logic                                    vec_credit
);
    timeunit 1ns;
    timeprecision 1ps;

    import mvm_cfg_pkg::*;

    // Failed assertions so far
    int fail_count = 0;

    // Result credits never above the reset value
    a_res_credit_max : assert property (@(posedge clk) disable iff (!rst_n)
        res_cnt <= RES_CNT_WIDTH'(RES_CREDITS))
        else begin
            fail_count++;
            $error("Result credit counter above its reset value");
        end

    // Column FIFO written while full
    a_no_write_full : assert property (@(posedge clk) disable iff (!rst_n)
        fifo_wr |-> !fifo_full)
        else begin
            fail_count++;
            $error("Column written into a full FIFO");
        end

    // Vector released with its last column and no new one yet
    // Nothing may issue in the next cycle
    a_issue_loaded : assert property (@(posedge clk) disable iff (!rst_n)
        (vec_credit && !vec_valid) |=> !issue)
        else begin
            fail_count++;
            $error("Column issued after the vector was released");
        end

endmodule

bind mvm_sequencer mvm_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_cnt    (res_cnt),
    .fifo_wr    (fifo_wr),
    .fifo_full  (fifo_full),
    .issue      (issue),
    .vec_valid  (vec_valid),
    .vec_credit (vec_credit)
);

//--- testbench/mvm_tb.sv
module mvm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mvm_cfg_pkg::*;
    import mvm_types_pkg::*;

    localparam int CLK_PERIOD  = 10;
    // 1 + 10 + 1 + 1 + 2 vectors over the five tests
    localparam int NUM_VECS    = 15;
    localparam int TOTAL_COLS  = NUM_VECS * MAT_WIDTH;
    localparam int WATCHDOG_NS = TOTAL_COLS * 50 * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst_n;
    logic vec_valid;
    vec_t vec_data;
    logic vec_credit;
    logic col_valid;
    vec_t col_data;
    logic col_last;
    logic col_credit;
    logic res_valid;
    res_t res_data;
    logic res_credit;
    logic cfg_we;
    csr_addr_t cfg_addr;
    logic [CFG_WIDTH-1:0] cfg_wdata;
    logic [CFG_WIDTH-1:0] cfg_rdata;
    logic error;

    // Sender credits and run totals
    int vec_avail = VEC_CREDITS;
    int col_avail = COL_CREDITS;
    int vec_credits_seen = 0;
    int col_credits_seen = 0;
    int vecs_sent = 0;
    int cols_sent = 0;
    int res_seen = 0;
    // Consumer side
    int pending = 0;
    bit hold_credits = 1'b0;
    logic [31:0] data_seed = 32'h5212_8767;
    logic [31:0] cons_seed = ~32'h5212_8767;
    // Reference state
    int cur_shift = FRAC_DEFAULT;
    vec_t cur_vec;
    res_t exp_q [$];
    bit clamp_q [$];
    bit exp_error = 1'b0;
    res_t exp_r;
    bit exp_c;
    int window_start;
    vec_t v;

    mvm_top u_mvm_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Dot product, arithmetic shift, clamp to result range
    function automatic res_t model_result(input vec_t a, input vec_t c, input int shift,
                                          output bit clamp);
        int sum;
        int shifted;
        int hi;
        int lo;
        hi = (1 << (RES_WIDTH - 1)) - 1;
        lo = -(1 << (RES_WIDTH - 1));
        sum = 0;
        for (int i = 0; i < MAT_HEIGHT; i++) begin
            sum = sum + int'(a[i]) * int'(c[i]);
        end
        shifted = sum >>> shift;
        clamp = (shifted > hi) || (shifted < lo);
        if (shifted > hi) begin
            return res_t'(hi);
        end else if (shifted < lo) begin
            return res_t'(lo);
        end
        return res_t'(shifted);
    endfunction

    // Mode 0 counts up, 1 random, 2 alternating extremes
    function automatic vec_t make_col(input int mode, input int j);
        vec_t c;
        for (int i = 0; i < MAT_HEIGHT; i++) begin
            case (mode)
                0: c[i] = elem_t'(j * MAT_HEIGHT + i + 1);
                1: begin
                    data_seed = xorshift32(data_seed);
                    c[i] = elem_t'(data_seed);
                end
                default: c[i] = (j % 2 == 0) ? elem_t'(127) : elem_t'(-128);
            endcase
        end
        return c;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_res(input string name, input res_t got, input res_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_cfg(input string name, input logic [CFG_WIDTH-1:0] got,
                             input logic [CFG_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Drivers, all called on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic write_cfg(input csr_addr_t addr, input logic [CFG_WIDTH-1:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    // Read data is combinational, sampled at the rising edge
    task automatic read_cfg(input csr_addr_t addr, input logic [CFG_WIDTH-1:0] exp,
                            input string name);
        cfg_addr = addr;
        @(posedge clk);
        check_cfg(name, cfg_rdata, exp);
        @(negedge clk);
    endtask

    task automatic set_shift(input int shift);
        write_cfg(ADDR_SHIFT, CFG_WIDTH'(shift));
        cur_shift = shift;
    endtask

    task automatic send_vec(input vec_t a);
        while (vec_avail == 0) @(negedge clk);
        vec_valid = 1'b1;
        vec_data  = a;
        vec_avail--;
        vecs_sent++;
        cur_vec = a;
        @(negedge clk);
        vec_valid = 1'b0;
    endtask

    // Expected value queued as the column goes out
    task automatic send_col(input vec_t c, input logic is_last);
        res_t r;
        bit cl;
        while (col_avail == 0) @(negedge clk);
        r = model_result(cur_vec, c, cur_shift, cl);
        exp_q.push_back(r);
        clamp_q.push_back(cl);
        col_valid = 1'b1;
        col_data  = c;
        col_last  = is_last;
        col_avail--;
        cols_sent++;
        @(negedge clk);
        col_valid = 1'b0;
        col_last  = 1'b0;
    endtask

    task automatic send_block(input vec_t a, input int mode);
        send_vec(a);
        for (int j = 0; j < MAT_WIDTH; j++) begin
            send_col(make_col(mode, j), j == MAT_WIDTH - 1);
        end
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Credits, consumer, compare
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n && vec_credit) begin
            vec_avail++;
            vec_credits_seen++;
        end
        if (rst_n && col_credit) begin
            col_avail++;
            col_credits_seen++;
        end
    end

    // Random return delay unless held
    always @(negedge clk) begin
        res_credit = 1'b0;
        if (rst_n && !hold_credits && pending > 0) begin
            cons_seed = xorshift32(cons_seed);
            if (cons_seed[0]) begin
                res_credit = 1'b1;
                pending--;
            end
        end
    end

    // Error flag lags the result that raised it by one cycle
    always @(posedge clk) begin
        if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("A result arrived while no result was expected");
            end
            exp_r = exp_q.pop_front();
            exp_c = clamp_q.pop_front();
            check_flag("error", error, exp_error);
            check_res("res_data", res_data, exp_r);
            exp_error = exp_error | exp_c;
            res_seen++;
            pending++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Regression failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        vec_valid  = 1'b0;
        vec_data   = '0;
        col_valid  = 1'b0;
        col_data   = '0;
        col_last   = 1'b0;
        res_credit = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("vec_credit", vec_credit, 1'b0);
        check_flag("col_credit", col_credit, 1'b0);
        check_flag("error", error, 1'b0);
        read_cfg('0, '0, "cfg_rdata");

        // Counting matrix, vector 1 to 5, no shift
        set_shift(0);
        for (int i = 0; i < MAT_HEIGHT; i++) begin
            v[i] = elem_t'(i + 1);
        end
        send_block(v, 0);
        drain_results();
        read_cfg(ADDR_COUNT, CFG_WIDTH'(MAT_WIDTH), "cfg_rdata");

        // Random data at default shift
        set_shift(FRAC_DEFAULT);
        read_cfg(ADDR_SHIFT, CFG_WIDTH'(FRAC_DEFAULT), "cfg_rdata");
        check_flag("error", error, 1'b0);
        repeat (10) send_block(make_col(1, 0), 1);
        drain_results();

        // Extremes, then clear the sticky flag
        v = '{default: elem_t'(127)};
        send_block(v, 2);
        drain_results();
        check_flag("error", error, 1'b1);
        read_cfg(ADDR_STATUS, 16'h0001, "cfg_rdata");
        write_cfg(ADDR_STATUS, 16'h0001);
        exp_error = 1'b0;
        check_flag("error", error, 1'b0);
        read_cfg(ADDR_STATUS, 16'h0000, "cfg_rdata");

        // Consumer holds back all result credits
        while (pending != 0) @(posedge clk);
        hold_credits = 1'b1;
        window_start = res_seen;
        fork
            begin
                @(negedge clk);
                send_block(make_col(1, 0), 1);
            end
            begin
                repeat (100) @(negedge clk);
                check_count("res_valid pulses", res_seen - window_start, RES_CREDITS);
                @(posedge clk);
                hold_credits = 1'b0;
            end
        join
        drain_results();

        // New shift for each of two vectors
        set_shift(2);
        send_block(make_col(1, 0), 1);
        drain_results();
        set_shift(6);
        read_cfg(ADDR_SHIFT, 16'h0006, "cfg_rdata");
        send_block(make_col(1, 0), 1);
        drain_results();

        check_count("vec_credit pulses", vec_credits_seen, vecs_sent);
        check_count("col_credit pulses", col_credits_seen, cols_sent);
        read_cfg(ADDR_COUNT, CFG_WIDTH'(cols_sent), "cfg_rdata");

        if (u_mvm_top.u_sequencer.u_assert.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Sequencer assertions failed during the run");
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule

//--- filelist.f
rtl/mvm_cfg_pkg.sv
rtl/mvm_types_pkg.sv
rtl/mvm_stream_if.sv
rtl/mvm_csr.sv
rtl/mvm_sequencer.sv
rtl/mvm_vector_mac.sv
rtl/mvm_top.sv
testbench/mvm_assert.sv
testbench/mvm_tb.sv

//--- Bender.yml
package:
  name: mvm

sources:
  - rtl/mvm_cfg_pkg.sv
  - rtl/mvm_types_pkg.sv
  - rtl/mvm_stream_if.sv
  - rtl/mvm_csr.sv
  - rtl/mvm_sequencer.sv
  - rtl/mvm_vector_mac.sv
  - rtl/mvm_top.sv
  - target: test
    files:
      - testbench/mvm_assert.sv
      - testbench/mvm_tb.sv
